// File: project.f
+incdir+source
source/rename_pkg.sv
source/rename_if.sv
source/map_table.sv
source/free_list.sv
source/rename_dispatch.sv
source/rename_top.sv
verif/rename_assert.sv
verif/rename_tb.sv

// File: Makefile
# Verilator flow for the rename stage testbench.
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/rename_tb.sv
// Rename stage testbench with directed tests checked against a reference model.
`default_nettype none

`include "rename_defs.svh"

module rename_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 8;
  localparam int RST_CYCLES  = 4;
  localparam int TEST_CYCLES = 6 * (RST_CYCLES + 20);   // Six tests of at most 20 busy cycles.

  logic clk = 1'b0;
  logic rst, req_valid_i, req_ready_o, is_branch_i, cdb_valid_i, commit_valid_i;
  logic mispredict_i, out_ready_i, out_valid_o, out_opa_rdy_o, out_opb_rdy_o;
  rename_pkg::areg_t opa_idx_i, opb_idx_i, dest_idx_i;
  rename_pkg::preg_t cdb_preg_i, commit_preg_i, out_opa_preg_o, out_opb_preg_o;
  rename_pkg::preg_t out_dest_preg_o, out_old_preg_o;

  // Reference model.
  rename_pkg::preg_t ref_map [`ARCH_REGS];
  rename_pkg::preg_t chk_map [`ARCH_REGS];
  logic [`ARCH_REGS-1:0] ref_rdy, chk_rdy;
  rename_pkg::preg_t free_q [$];
  rename_pkg::preg_t spec_q [$];                         // Taken since the checkpoint.
  rename_pkg::preg_t exp_a, exp_b, exp_dest, exp_old;    // Last accepted packet.
  logic exp_ra, exp_rb;
  logic [31:0] lfsr = 32'h6a02_81d5;

  rename_top i_rename_top (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic rename_pkg::areg_t rand_areg();
    rename_pkg::areg_t v;
    for (int i = 0; i < `AREG_W; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);   // Galois step.
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string test, input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("** Error %s: %s expected %0d, actual %0d", test, what, exp, act);
      abort_run("stopped at the first mismatch");
    end
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    {req_valid_i, is_branch_i, cdb_valid_i, commit_valid_i, mispredict_i} = '0;
    {opa_idx_i, opb_idx_i, dest_idx_i, cdb_preg_i, commit_preg_i} = '0;
    out_ready_i = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < `ARCH_REGS; i++) ref_map[i] = rename_pkg::preg_t'(i);   // Identity.
    ref_rdy = '1;
    chk_map = ref_map;
    chk_rdy = ref_rdy;
    free_q.delete();
    spec_q.delete();
    for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) free_q.push_back(rename_pkg::preg_t'(i));
  endtask

  task automatic apply_cdb(input rename_pkg::preg_t tag);
    for (int i = 0; i < `ARCH_REGS; i++) begin
      if (ref_map[i] == tag) ref_rdy[i] = 1'b1;
      if (chk_map[i] == tag) chk_rdy[i] = 1'b1;   // Saved copy wakes up too.
    end
  endtask

  // Drives one request, waits for acceptance and updates the model.
  task automatic issue(input rename_pkg::areg_t a, b, d, input logic br);
    req_valid_i = 1'b1;
    opa_idx_i   = a;
    opb_idx_i   = b;
    dest_idx_i  = d;
    is_branch_i = br;
    #1;
    while (!req_ready_o) begin
      @(negedge clk);
      #1;
    end
    exp_a   = ref_map[a];
    exp_b   = ref_map[b];
    exp_ra  = ref_rdy[a] || (cdb_valid_i && cdb_preg_i == exp_a);   // Same-cycle bypass.
    exp_rb  = ref_rdy[b] || (cdb_valid_i && cdb_preg_i == exp_b);
    exp_old = ref_map[d];
    if (cdb_valid_i) apply_cdb(cdb_preg_i);
    exp_dest = free_q.pop_front();
    ref_map[d] = exp_dest;
    ref_rdy[d] = 1'b0;                                             // Write beats wakeup.
    if (br) begin
      chk_map = ref_map;
      chk_rdy = ref_rdy;
      spec_q.delete();
    end else begin
      spec_q.push_back(exp_dest);
    end
    @(negedge clk);
    {req_valid_i, is_branch_i, cdb_valid_i} = '0;
  endtask

  task automatic check_pkt(input string test);
    check_val(test, "out_valid", 1, int'(out_valid_o));
    check_val(test, "opa_preg", int'(exp_a), int'(out_opa_preg_o));
    check_val(test, "opa_rdy", int'(exp_ra), int'(out_opa_rdy_o));
    check_val(test, "opb_preg", int'(exp_b), int'(out_opb_preg_o));
    check_val(test, "opb_rdy", int'(exp_rb), int'(out_opb_rdy_o));
    check_val(test, "dest_preg", int'(exp_dest), int'(out_dest_preg_o));
    check_val(test, "old_preg", int'(exp_old), int'(out_old_preg_o));
  endtask

  task automatic rename(input string test, input rename_pkg::areg_t a, b, d, input logic br);
    issue(a, b, d, br);
    check_pkt(test);
  endtask

  task automatic broadcast(input rename_pkg::preg_t tag);
    cdb_valid_i = 1'b1;
    cdb_preg_i  = tag;
    @(negedge clk);
    cdb_valid_i = 1'b0;
    apply_cdb(tag);
  endtask

  task automatic commit(input rename_pkg::preg_t tag);
    commit_valid_i = 1'b1;
    commit_preg_i  = tag;
    @(negedge clk);
    commit_valid_i = 1'b0;
    free_q.push_back(tag);
  endtask

  task automatic read_after_reset();
    reset_dut();
    check_val("reset_read", "out_valid", 0, int'(out_valid_o));
    check_val("reset_read", "req_ready", 1, int'(req_ready_o));
    rename("reset_read", rand_areg(), rand_areg(), rand_areg(), 1'b0);
  endtask

  task automatic chain_dependents();
    reset_dut();
    rename("dep_chain", rand_areg(), rand_areg(), 3'd1, 1'b0);
    rename("dep_chain", 3'd1, rand_areg(), 3'd2, 1'b0);   // Reads the fresh tag.
    rename("dep_chain", 3'd2, 3'd1, 3'd1, 1'b0);
  endtask

  task automatic wake_on_cdb();
    reset_dut();
    rename("cdb_wakeup", rand_areg(), rand_areg(), 3'd4, 1'b0);
    broadcast(ref_map[4]);
    rename("cdb_wakeup", 3'd4, rand_areg(), 3'd5, 1'b0);
    rename("cdb_wakeup", rand_areg(), 3'd5, 3'd6, 1'b0);
    cdb_valid_i = 1'b1;                                   // Completes during the read.
    cdb_preg_i  = ref_map[6];
    rename("cdb_wakeup", 3'd6, 3'd5, 3'd7, 1'b0);
  endtask

  task automatic drain_and_commit();
    reset_dut();
    while (free_q.size() > 0) rename("drain_commit", rand_areg(), rand_areg(), rand_areg(), 1'b0);
    check_val("drain_commit", "req_ready", 0, int'(req_ready_o));
    commit(exp_old);
    rename("drain_commit", rand_areg(), rand_areg(), rand_areg(), 1'b0);
  endtask

  task automatic recover_mispredict();
    reset_dut();
    rename("mispredict", rand_areg(), rand_areg(), 3'd2, 1'b1);   // Branch takes the snapshot.
    rename("mispredict", 3'd2, rand_areg(), 3'd3, 1'b0);
    rename("mispredict", rand_areg(), 3'd3, 3'd2, 1'b0);
    out_ready_i  = 1'b0;                                  // Keeps the last packet pending.
    mispredict_i = 1'b1;
    @(negedge clk);
    mispredict_i = 1'b0;
    out_ready_i  = 1'b1;
    check_val("mispredict", "out_valid", 0, int'(out_valid_o));
    ref_map = chk_map;
    ref_rdy = chk_rdy;
    while (spec_q.size() > 0) free_q.push_front(spec_q.pop_back());   // Head rolls back.
    rename("mispredict", 3'd2, 3'd3, 3'd4, 1'b0);
  endtask

  task automatic hold_under_backpressure();
    reset_dut();
    out_ready_i = 1'b0;
    rename("backpressure", 3'd1, 3'd2, 3'd3, 1'b0);
    req_valid_i = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_val("backpressure", "req_ready", 0, int'(req_ready_o));
      check_pkt("backpressure");                           // First packet still held.
    end
    out_ready_i = 1'b1;
    rename("backpressure", 3'd3, 3'd1, 3'd4, 1'b0);
  endtask

  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + 100));
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    read_after_reset();
    chain_dependents();
    wake_on_cdb();
    drain_and_commit();
    recover_mispredict();
    hold_under_backpressure();
    if (i_rename_top.i_rename_assert.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("bound assertions reported failures");
    end
  end

endmodule

`default_nettype wire

// File: verif/rename_assert.sv
// Rename stage checker for the held output packet, free-list occupancy and stall on empty.
`default_nettype none

`include "rename_defs.svh"

module rename_assert (
  input logic                 clk,
  input logic                 rst,
  input logic                 req_ready_i,
  input logic                 mispredict_i,
  input logic                 out_ready_i,
  input logic                 out_valid_i,
  input logic                 opa_rdy_i,
  input logic                 opb_rdy_i,
  input logic [4*`PREG_W-1:0] pkt_tags_i,   // Operand, destination and old tags.
  input rename_pkg::fl_cnt_t  fl_count_i,
  input logic                 fl_empty_i    // Head pointer has caught up with the tail.
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;   // Count of assertion failures.

  // Held packet keeps its tags. Readiness only rises through wakeup.
  hold_a: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i && !mispredict_i |=> out_valid_i && $stable(pkt_tags_i)
      && (opa_rdy_i || !$past(opa_rdy_i)) && (opb_rdy_i || !$past(opb_rdy_i)))
    else begin
      fail_cnt++;
      $error("Rename packet changed while held");
    end

  count_a: assert property (@(posedge clk) disable iff (rst) fl_count_i <= `PHYS_REGS)
    else begin
      fail_cnt++;
      $error("Free-list count above capacity");
    end

  // No request taken without a tag.
  stall_a: assert property (@(posedge clk) disable iff (rst) fl_empty_i |-> !req_ready_i)
    else begin
      fail_cnt++;
      $error("Request ready with an empty free list");
    end

endmodule

bind rename_top rename_assert i_rename_assert (
  .clk          (clk),
  .rst          (rst),
  .req_ready_i  (req_ready_o),
  .mispredict_i (mispredict_i),
  .out_ready_i  (out_ready_i),
  .out_valid_i  (out_valid_o),
  .opa_rdy_i    (out_opa_rdy_o),
  .opb_rdy_i    (out_opb_rdy_o),
  .pkt_tags_i   ({out_opa_preg_o, out_opb_preg_o, out_dest_preg_o, out_old_preg_o}),
  .fl_count_i   (i_free_list.count_q),
  .fl_empty_i   (i_free_list.head_q == i_free_list.tail_q)
);

`default_nettype wire

// File: source/rename_top.sv
// Register rename stage top level joining map table, free list and dispatch.
`default_nettype none

module rename_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,     // Rename request.
  output logic              req_ready_o,
  input  rename_pkg::areg_t opa_idx_i,
  input  rename_pkg::areg_t opb_idx_i,
  input  rename_pkg::areg_t dest_idx_i,
  input  logic              is_branch_i,     // Take the checkpoint.
  input  logic              cdb_valid_i,     // Completion broadcast.
  input  rename_pkg::preg_t cdb_preg_i,
  input  logic              commit_valid_i,  // Old tag returned at retirement.
  input  rename_pkg::preg_t commit_preg_i,
  input  logic              mispredict_i,    // Restore the checkpoint.
  input  logic              out_ready_i,
  output logic              out_valid_o,     // Rename packet.
  output rename_pkg::preg_t out_opa_preg_o,
  output logic              out_opa_rdy_o,
  output rename_pkg::preg_t out_opb_preg_o,
  output logic              out_opb_rdy_o,
  output rename_pkg::preg_t out_dest_preg_o,
  output rename_pkg::preg_t out_old_preg_o
);

  logic              alloc_en;
  rename_pkg::preg_t alloc_preg;
  logic              fl_empty;

  rename_if rn_if ();

  map_table i_map_table (
    .clk          (clk),
    .rst          (rst),
    .rn           (rn_if.tbl),
    .cdb_valid_i  (cdb_valid_i),
    .cdb_preg_i   (cdb_preg_i),
    .mispredict_i (mispredict_i)
  );

  free_list i_free_list (
    .clk            (clk),
    .rst            (rst),
    .alloc_en_i     (alloc_en),
    .alloc_preg_o   (alloc_preg),
    .empty_o        (fl_empty),
    .commit_valid_i (commit_valid_i),
    .commit_preg_i  (commit_preg_i),
    .chk_save_i     (rn_if.chk_save),   // Same strobe the table snapshots on.
    .mispredict_i   (mispredict_i)
  );

  rename_dispatch i_rename_dispatch (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .opa_idx_i       (opa_idx_i),
    .opb_idx_i       (opb_idx_i),
    .dest_idx_i      (dest_idx_i),
    .is_branch_i     (is_branch_i),
    .rn              (rn_if.disp),
    .alloc_en_o      (alloc_en),
    .alloc_preg_i    (alloc_preg),
    .empty_i         (fl_empty),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_preg_i      (cdb_preg_i),
    .mispredict_i    (mispredict_i),
    .out_ready_i     (out_ready_i),
    .out_valid_o     (out_valid_o),
    .out_opa_preg_o  (out_opa_preg_o),
    .out_opa_rdy_o   (out_opa_rdy_o),
    .out_opb_preg_o  (out_opb_preg_o),
    .out_opb_rdy_o   (out_opb_rdy_o),
    .out_dest_preg_o (out_dest_preg_o),
    .out_old_preg_o  (out_old_preg_o)
  );

endmodule

`default_nettype wire

// File: source/rename_dispatch.sv
// Rename dispatch accepting requests and registering the combined rename packet.
`default_nettype none

module rename_dispatch (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  rename_pkg::areg_t opa_idx_i,
  input  rename_pkg::areg_t opb_idx_i,
  input  rename_pkg::areg_t dest_idx_i,
  input  logic              is_branch_i,
  rename_if.disp            rn,               // Map table lookups and write.
  output logic              alloc_en_o,       // Pop the free list.
  input  rename_pkg::preg_t alloc_preg_i,
  input  logic              empty_i,
  input  logic              cdb_valid_i,      // Wakeup for a held packet.
  input  rename_pkg::preg_t cdb_preg_i,
  input  logic              mispredict_i,
  input  logic              out_ready_i,
  output logic              out_valid_o,
  output rename_pkg::preg_t out_opa_preg_o,
  output logic              out_opa_rdy_o,
  output rename_pkg::preg_t out_opb_preg_o,
  output logic              out_opb_rdy_o,
  output rename_pkg::preg_t out_dest_preg_o,
  output rename_pkg::preg_t out_old_preg_o
);

  logic accept;   // Request taken this cycle.

  // Room when the register is empty or draining this cycle.
  assign req_ready_o = !empty_i && !mispredict_i && (!out_valid_o || out_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  assign rn.opa_idx  = opa_idx_i;
  assign rn.opb_idx  = opb_idx_i;
  assign rn.dest_idx = dest_idx_i;
  assign rn.new_preg = alloc_preg_i;
  assign rn.wr_en    = accept;
  assign rn.chk_save = accept && is_branch_i;   // Snapshot on a branch.
  assign alloc_en_o  = accept;

  // Output valid.
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (mispredict_i) begin
      out_valid_o <= 1'b0;                      // Wrong-path packet dropped.
    end else if (accept) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  // Packet payload.
  always_ff @(posedge clk) begin
    if (accept) begin
      out_opa_preg_o  <= rn.opa_preg;
      out_opa_rdy_o   <= rn.opa_rdy;
      out_opb_preg_o  <= rn.opb_preg;
      out_opb_rdy_o   <= rn.opb_rdy;
      out_dest_preg_o <= alloc_preg_i;
      out_old_preg_o  <= rn.old_preg;
    end else if (cdb_valid_i) begin
      // A stalled packet tracks completions.
      if (cdb_preg_i == out_opa_preg_o) begin
        out_opa_rdy_o <= 1'b1;
      end
      if (cdb_preg_i == out_opb_preg_o) begin
        out_opb_rdy_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/free_list.sv
// Free list as a circular queue of physical tags with commit return and a saved head.
`default_nettype none

`include "rename_defs.svh"

module free_list (
  input  logic              clk,
  input  logic              rst,
  input  logic              alloc_en_i,      // Pop the head.
  output rename_pkg::preg_t alloc_preg_o,    // Head entry, valid when not empty.
  output logic              empty_o,
  input  logic              commit_valid_i,  // Push at the tail.
  input  rename_pkg::preg_t commit_preg_i,
  input  logic              chk_save_i,      // Branch renamed this cycle.
  input  logic              mispredict_i     // Roll the head back.
);

  rename_pkg::rec_state_t rec_state;

  rename_pkg::preg_t fifo_q [`PHYS_REGS];

  // Pointers carry a wrap bit above the index so that full and empty differ.
  rename_pkg::fl_cnt_t head_q;
  rename_pkg::fl_cnt_t tail_q;
  rename_pkg::fl_cnt_t chk_head_q;
  rename_pkg::fl_cnt_t count_q;
  rename_pkg::fl_cnt_t head_nxt;
  rename_pkg::fl_cnt_t tail_nxt;

  assign rec_state = mispredict_i ? rename_pkg::REC_RESTORE : rename_pkg::REC_NORMAL;

  assign head_nxt = head_q + rename_pkg::fl_cnt_t'(alloc_en_i);
  assign tail_nxt = tail_q + rename_pkg::fl_cnt_t'(commit_valid_i);

  assign alloc_preg_o = fifo_q[head_q[`PREG_W-1:0]];
  assign empty_o      = (count_q == '0);

  // Queue storage, preloaded with the tags not in the reset map.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        fifo_q[i] <= rename_pkg::preg_t'(i + `ARCH_REGS);
      end
    end else if (commit_valid_i) begin
      fifo_q[tail_q[`PREG_W-1:0]] <= commit_preg_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q     <= '0;
      tail_q     <= rename_pkg::fl_cnt_t'(`ARCH_REGS);
      count_q    <= rename_pkg::fl_cnt_t'(`ARCH_REGS);
      chk_head_q <= '0;
    end else begin
      tail_q <= tail_nxt;                          // Commits append in both modes.
      case (rec_state)
        rename_pkg::REC_NORMAL: begin
          head_q  <= head_nxt;
          count_q <= count_q + rename_pkg::fl_cnt_t'(commit_valid_i)
                     - rename_pkg::fl_cnt_t'(alloc_en_i);
          if (chk_save_i && alloc_en_i) begin
            chk_head_q <= head_nxt;                // Head past the branch's own tag.
          end
        end
        rename_pkg::REC_RESTORE: begin
          head_q  <= chk_head_q;
          count_q <= tail_nxt - chk_head_q;        // Includes commits since the snapshot.
        end
        default: begin
          head_q <= head_q;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/map_table.sv
// Map table holding a tag and ready bit per architectural register, with one checkpoint.
`default_nettype none

`include "rename_defs.svh"

module map_table (
  input  logic              clk,
  input  logic              rst,
  rename_if.tbl             rn,            // Lookups and writes from dispatch.
  input  logic              cdb_valid_i,   // CDB broadcast strobe.
  input  rename_pkg::preg_t cdb_preg_i,    // Tag that just completed.
  input  logic              mispredict_i   // Restore from the checkpoint.
);

  rename_pkg::rec_state_t rec_state;

  // Live map and ready bits.
  rename_pkg::preg_t [`ARCH_REGS-1:0] map_q;
  rename_pkg::preg_t [`ARCH_REGS-1:0] map_d;
  logic [`ARCH_REGS-1:0]              rdy_q;
  logic [`ARCH_REGS-1:0]              rdy_d;

  // Single checkpoint, taken on a branch rename.
  rename_pkg::preg_t [`ARCH_REGS-1:0] chk_map_q;
  logic [`ARCH_REGS-1:0]              chk_rdy_q;

  logic [`ARCH_REGS-1:0] cdb_hit;       // Live entries holding the CDB tag.
  logic [`ARCH_REGS-1:0] chk_cdb_hit;   // Checkpoint entries holding the CDB tag.

  assign rec_state = mispredict_i ? rename_pkg::REC_RESTORE : rename_pkg::REC_NORMAL;

  // Tag compare against every entry, live and saved.
  always_comb begin
    for (int i = 0; i < `ARCH_REGS; i++) begin
      cdb_hit[i]     = cdb_valid_i && (map_q[i] == cdb_preg_i);
      chk_cdb_hit[i] = cdb_valid_i && (chk_map_q[i] == cdb_preg_i);
    end
  end

  // Reads come straight from the current contents.
  assign rn.opa_preg = map_q[rn.opa_idx];
  assign rn.opb_preg = map_q[rn.opb_idx];
  assign rn.old_preg = map_q[rn.dest_idx];   // Freed later at retirement.

  // A tag finishing this cycle reads as ready at once.
  assign rn.opa_rdy = rdy_q[rn.opa_idx] | cdb_hit[rn.opa_idx];
  assign rn.opb_rdy = rdy_q[rn.opb_idx] | cdb_hit[rn.opb_idx];

  // Next-state selection.
  always_comb begin
    map_d = map_q;
    rdy_d = rdy_q;
    case (rec_state)
      rename_pkg::REC_NORMAL: begin
        rdy_d = rdy_q | cdb_hit;                  // Wakeup.
        if (rn.wr_en) begin
          map_d[rn.dest_idx] = rn.new_preg;
          rdy_d[rn.dest_idx] = 1'b0;              // New producer, write beats wakeup.
        end
      end
      rename_pkg::REC_RESTORE: begin
        map_d = chk_map_q;                        // Single-cycle rollback.
        rdy_d = chk_rdy_q | chk_cdb_hit;          // Keep a completion seen this cycle.
      end
      default: begin
        map_d = map_q;
        rdy_d = rdy_q;
      end
    endcase
  end

  // Live state.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map_q[i] <= rename_pkg::preg_t'(i);       // Identity mapping.
      end
      rdy_q <= '1;                                // Everything committed.
    end else begin
      map_q <= map_d;
      rdy_q <= rdy_d;
    end
  end

  // Checkpoint state.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        chk_map_q[i] <= rename_pkg::preg_t'(i);   // Matches the reset map.
      end
      chk_rdy_q <= '1;
    end else if (rn.wr_en && rn.chk_save) begin
      chk_map_q <= map_d;                         // Snapshot includes the branch's own write.
      chk_rdy_q <= rdy_d;
    end else begin
      // Saved producers may complete before the branch resolves.
      chk_rdy_q <= chk_rdy_q | chk_cdb_hit;
    end
  end

endmodule

`default_nettype wire

// File: source/rename_if.sv
// Dispatch to map table interface carrying lookups, the new mapping and the checkpoint strobe.
`default_nettype none

interface rename_if;

  // Driven by the dispatch block.
  rename_pkg::areg_t opa_idx;    // Operand A lookup.
  rename_pkg::areg_t opb_idx;    // Operand B lookup.
  rename_pkg::areg_t dest_idx;   // Destination lookup and write index.
  rename_pkg::preg_t new_preg;   // Tag from the free list.
  logic              wr_en;      // Request accepted this cycle.
  logic              chk_save;   // Branch accepted, snapshot after the write.

  // Driven by the map table, combinational.
  rename_pkg::preg_t opa_preg;
  rename_pkg::preg_t opb_preg;
  logic              opa_rdy;    // Includes same-cycle CDB bypass.
  logic              opb_rdy;
  rename_pkg::preg_t old_preg;   // Previous mapping of dest_idx.

  modport disp (
    output opa_idx, opb_idx, dest_idx, new_preg, wr_en, chk_save,
    input  opa_preg, opb_preg, opa_rdy, opb_rdy, old_preg
  );

  // Map table side.
  modport tbl (
    input  opa_idx, opb_idx, dest_idx, new_preg, wr_en, chk_save,
    output opa_preg, opb_preg, opa_rdy, opb_rdy, old_preg
  );

endinterface

`default_nettype wire

// File: source/rename_pkg.sv
// Rename package with the register index, tag, occupancy and recovery types.
`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

  // Architectural register index, 0 to ARCH_REGS-1.
  typedef logic [`AREG_W-1:0] areg_t;

  // Physical register tag.
  typedef logic [`PREG_W-1:0] preg_t;

  // Free-list count, also used for the wrapping queue pointers.
  typedef logic [`FL_CNT_W-1:0] fl_cnt_t;

  // Recovery mode of the map table and the free list.
  typedef enum logic {
    REC_NORMAL,   // Regular rename, wakeup and commit.
    REC_RESTORE   // Mispredict, reload from the checkpoint.
  } rec_state_t;

endpackage

`default_nettype wire

// File: source/rename_defs.svh
// Rename stage sizing macros for register counts and index widths.
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural register file.
`define ARCH_REGS 8
`define AREG_W    3

// Physical register file, one tag per entry.
`define PHYS_REGS 16
`define PREG_W    4

// Free-list occupancy, holds 0 to PHYS_REGS.
`define FL_CNT_W  5

`endif
